// File: isaPkg.sv
package isaPkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////
	localparam int xlen    = 32;
	localparam int instW   = 32;
	localparam int regIdxW = 5;

	//////////////////////////////////////////////////
	// major opcodes
	//////////////////////////////////////////////////
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opBranch = 7'b1100011;

	// funct3 for OP and OP-IMM.
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101; // also sra.
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// funct3 for branches.
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd,
		aluPassB // lui.
	} aluOpT;

endpackage

// File: pipePkg.sv
package pipePkg;

	typedef enum logic [1:0] {opAReg, opAPc, opAZero} opASelT;
	typedef enum logic {opBReg, opBImm} opBSelT;

	// decode to execute.
	typedef struct packed {
		logic                         valid;
		logic [isaPkg::xlen-1:0]      pc;
		logic [isaPkg::xlen-1:0]      rs1Val;
		logic [isaPkg::xlen-1:0]      rs2Val;
		logic [isaPkg::xlen-1:0]      imm;
		logic [isaPkg::regIdxW-1:0]   rd;
		isaPkg::aluOpT                aluOp;
		opASelT                       opASel;
		opBSelT                       opBSel;
		logic                         isBranch;
		logic                         isJal;
		logic [2:0]                   funct3;
		logic                         regWrite;
	} decExecT;

	// execute to retire.
	typedef struct packed {
		logic                         valid;
		logic [isaPkg::xlen-1:0]      pc;
		logic [isaPkg::regIdxW-1:0]   rd;
		logic [isaPkg::xlen-1:0]      value;
		logic                         regWrite;
	} execRetT;

	typedef enum logic {runSt, redirectSt} ctlStateT;

endpackage

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                        clk,
	input  logic [isaPkg::regIdxW-1:0]  raddr1,
	input  logic [isaPkg::regIdxW-1:0]  raddr2,
	output logic [isaPkg::xlen-1:0]     rdata1,
	output logic [isaPkg::xlen-1:0]     rdata2,
	input  logic                        we,
	input  logic [isaPkg::regIdxW-1:0]  waddr,
	input  logic [isaPkg::xlen-1:0]     wdata
);
	import isaPkg::*;

	logic [xlen-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (we && waddr != '0) begin // x0 stays unwritten.
			regs[waddr] <= wdata;
		end
	end

	// async read, x0 muxed to zero.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
	input  logic                        clk,
	input  logic [isaPkg::instW-1:0]    inst,
	input  logic [isaPkg::xlen-1:0]     instPc,
	input  logic                        instKeep,
	input  logic                        exFwdValid,
	input  logic [isaPkg::regIdxW-1:0]  exFwdRd,
	input  logic [isaPkg::xlen-1:0]     exFwdValue,
	input  logic                        rtFwdValid,
	input  logic [isaPkg::regIdxW-1:0]  rtFwdRd,
	input  logic [isaPkg::xlen-1:0]     rtFwdValue,
	input  logic                        wrEn,
	input  logic [isaPkg::regIdxW-1:0]  wrRd,
	input  logic [isaPkg::xlen-1:0]     wrValue,
	output pipePkg::decExecT            deOut
);
	import isaPkg::*;
	import pipePkg::*;

	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	logic [regIdxW-1:0] rs1;
	logic [regIdxW-1:0] rs2;
	logic [regIdxW-1:0] rd;
	logic [xlen-1:0]    immI;
	logic [xlen-1:0]    immU;
	logic [xlen-1:0]    immB;
	logic [xlen-1:0]    immJ;
	logic [xlen-1:0]    rf1;
	logic [xlen-1:0]    rf2;
	aluOpT              arithOp;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immU = {inst[31:12], 12'b0};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	regFile regs (
		.clk    (clk),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rf1),
		.rdata2 (rf2),
		.we     (wrEn),
		.waddr  (wrRd),
		.wdata  (wrValue)
	);

	// youngest producer wins.
	function automatic logic [xlen-1:0] fwd(input logic [regIdxW-1:0] rs,
			input logic [xlen-1:0] rfVal);
		if (rs == '0)
			return '0;
		if (exFwdValid && exFwdRd == rs)
			return exFwdValue;
		if (rtFwdValid && rtFwdRd == rs)
			return rtFwdValue;
		return rfVal;
	endfunction

	always_comb begin
		arithOp = aluAdd;
		case (funct3)
			f3AddSub: arithOp = (opcode == opOp && funct7[5]) ? aluSub : aluAdd;
			f3Sll:    arithOp = aluSll;
			f3Slt:    arithOp = aluSlt;
			f3Sltu:   arithOp = aluSltu;
			f3Xor:    arithOp = aluXor;
			f3Srl:    arithOp = funct7[5] ? aluSra : aluSrl;
			f3Or:     arithOp = aluOr;
			f3And:    arithOp = aluAnd;
		endcase
	end

	always_comb begin
		deOut        = '0;
		deOut.pc     = instPc;
		deOut.rs1Val = fwd(rs1, rf1);
		deOut.rs2Val = fwd(rs2, rf2);
		deOut.funct3 = funct3;
		deOut.rd     = rd;
		case (opcode)
			opOp: begin
				deOut.aluOp    = arithOp;
				deOut.regWrite = 1'b1;
			end
			opImm: begin
				deOut.aluOp    = arithOp;
				deOut.opBSel   = opBImm;
				deOut.imm      = immI; // shamt sits in imm[4:0].
				deOut.regWrite = 1'b1;
			end
			opLui: begin
				deOut.aluOp    = aluPassB;
				deOut.opASel   = opAZero;
				deOut.opBSel   = opBImm;
				deOut.imm      = immU;
				deOut.regWrite = 1'b1;
			end
			opAuipc: begin
				deOut.opASel   = opAPc;
				deOut.opBSel   = opBImm;
				deOut.imm      = immU;
				deOut.regWrite = 1'b1;
			end
			opJal: begin
				deOut.isJal    = 1'b1;
				deOut.imm      = immJ;
				deOut.regWrite = 1'b1;
			end
			opBranch: begin
				deOut.isBranch = 1'b1;
				deOut.imm      = immB;
				deOut.rd       = '0;
			end
			default: deOut.rd = '0; // unsupported, retires as a no-op.
		endcase
		deOut.valid = instKeep;
		if (!instKeep)
			deOut.regWrite = 1'b0;
	end

endmodule

// File: stageReg.sv
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    hold,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// zero payload means valid and regWrite low.
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// File: executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
	input  pipePkg::decExecT         ex,
	output pipePkg::execRetT         result,
	output logic                     branchTaken,
	output logic [isaPkg::xlen-1:0]  target
);
	import isaPkg::*;
	import pipePkg::*;

	logic [xlen-1:0]         opA;
	logic [xlen-1:0]         opB;
	logic [xlen-1:0]         aluRes;
	logic [$clog2(xlen)-1:0] shamt;
	logic                    cond;
	logic                    doWrite;

	always_comb begin
		case (ex.opASel)
			opAReg:  opA = ex.rs1Val;
			opAPc:   opA = ex.pc;
			default: opA = '0;
		endcase
		opB = (ex.opBSel == opBImm) ? ex.imm : ex.rs2Val;
	end

	assign shamt = opB[$clog2(xlen)-1:0];

	always_comb begin
		case (ex.aluOp)
			aluAdd:   aluRes = opA + opB;
			aluSub:   aluRes = opA - opB;
			aluSll:   aluRes = opA << shamt;
			aluSlt:   aluRes = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluSltu:  aluRes = {{(xlen-1){1'b0}}, opA < opB};
			aluXor:   aluRes = opA ^ opB;
			aluSrl:   aluRes = opA >> shamt;
			aluSra:   aluRes = $signed(opA) >>> shamt;
			aluOr:    aluRes = opA | opB;
			aluAnd:   aluRes = opA & opB;
			default:  aluRes = opB; // passB.
		endcase
	end

	////////////////////////////////////////////////////
	// branch resolution
	////////////////////////////////////////////////////
	always_comb begin
		case (ex.funct3)
			f3Beq:   cond = ex.rs1Val == ex.rs2Val;
			f3Bne:   cond = ex.rs1Val != ex.rs2Val;
			f3Blt:   cond = $signed(ex.rs1Val) < $signed(ex.rs2Val);
			f3Bge:   cond = $signed(ex.rs1Val) >= $signed(ex.rs2Val);
			f3Bltu:  cond = ex.rs1Val < ex.rs2Val;
			f3Bgeu:  cond = ex.rs1Val >= ex.rs2Val;
			default: cond = 1'b0;
		endcase
	end

	assign branchTaken = ex.valid && (ex.isJal || (ex.isBranch && cond));
	assign target      = ex.pc + ex.imm;

	assign doWrite = ex.valid && ex.regWrite;

	always_comb begin
		result.valid    = ex.valid;
		result.pc       = ex.pc;
		result.rd       = ex.rd;
		result.regWrite = doWrite;
		if (!doWrite || ex.rd == '0)
			result.value = '0; // rd 0 always reports zero.
		else if (ex.isJal)
			result.value = ex.pc + xlen'(4);
		else
			result.value = aluRes;
	end

endmodule

// File: pipeControl.sv
`timescale 1ns/1ps

module pipeControl (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     instValid,
	input  logic [isaPkg::xlen-1:0]  instPc,
	input  logic                     erValid,
	input  logic                     creditAvail,
	input  logic                     branchTaken,
	input  logic [isaPkg::xlen-1:0]  target,
	output logic                     inReady,
	output logic                     instKeep,
	output logic                     deHold,
	output logic                     erHold,
	output logic                     deFlush,
	output logic                     retValid
);
	import isaPkg::*;
	import pipePkg::*;

	ctlStateT        state;
	logic [xlen-1:0] tgtQ;
	logic            readyQ;
	logic            advance;
	logic            accept;
	logic            onTarget;

	// retire slot frees when empty or when sending.
	assign advance  = !erValid || creditAvail;
	assign retValid = erValid && creditAvail;
	assign deHold   = !advance;
	assign erHold   = !advance;
	assign deFlush  = advance && branchTaken;

	assign inReady  = readyQ && advance;
	assign accept   = instValid && inReady;
	assign onTarget = instPc == tgtQ;

	// wrong path enters deReg as a bubble.
	assign instKeep = accept && (state == runSt || onTarget);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state  <= runSt;
			readyQ <= 1'b0;
		end else begin
			readyQ <= 1'b1;
			if (deFlush)
				state <= redirectSt;
			else if (state == redirectSt && accept && onTarget)
				state <= runSt;
		end
	end

	always_ff @(posedge clk) begin
		if (deFlush)
			tgtQ <= target;
	end

endmodule

// File: creditCounter.sv
`timescale 1ns/1ps

module creditCounter #(
	parameter int retCredits = 4
) (
	input  logic clk,
	input  logic rstN,
	input  logic send,
	input  logic creditReturn,
	output logic creditAvail
);

	localparam int cntW = $clog2(retCredits + 1);

	logic [cntW-1:0] count;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= cntW'(retCredits);
		end else if (send && !creditReturn) begin
			count <= count - 1'b1;
		end else if (creditReturn && !send) begin
			count <= count + 1'b1;
		end
		// both at once leaves count as is.
	end

	assign creditAvail = count != '0;

endmodule

// File: coreTop.sv
`timescale 1ns/1ps

module coreTop #(
	parameter int retCredits = 4
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        instValid,
	input  logic [isaPkg::xlen-1:0]     instPc,
	input  logic [isaPkg::instW-1:0]    inst,
	output logic                        inReady,
	output logic                        retValid,
	output logic [isaPkg::xlen-1:0]     retPc,
	output logic [isaPkg::regIdxW-1:0]  retRd,
	output logic [isaPkg::xlen-1:0]     retValue,
	input  logic                        retCredit
);
	import isaPkg::*;
	import pipePkg::*;

	decExecT         deD;
	decExecT         deQ;
	execRetT         erD;
	execRetT         erQ;
	logic            instKeep;
	logic            deHold;
	logic            erHold;
	logic            deFlush;
	logic            branchTaken;
	logic [xlen-1:0] target;
	logic            creditAvail;
	logic            rfWrite;

	assign rfWrite  = retValid && erQ.regWrite;
	assign retPc    = erQ.pc;
	assign retRd    = erQ.rd;
	assign retValue = erQ.value;

	decodeUnit decode (
		.clk        (clk),
		.inst       (inst),
		.instPc     (instPc),
		.instKeep   (instKeep),
		.exFwdValid (erD.regWrite),
		.exFwdRd    (erD.rd),
		.exFwdValue (erD.value),
		.rtFwdValid (erQ.regWrite),
		.rtFwdRd    (erQ.rd),
		.rtFwdValue (erQ.value),
		.wrEn       (rfWrite),
		.wrRd       (erQ.rd),
		.wrValue    (erQ.value),
		.deOut      (deD)
	);

	stageReg #(.payloadT(decExecT)) deReg (
		.clk   (clk),
		.rstN  (rstN),
		.hold  (deHold),
		.flush (deFlush),
		.d     (deD),
		.q     (deQ)
	);

	executeUnit execute (
		.ex          (deQ),
		.result      (erD),
		.branchTaken (branchTaken),
		.target      (target)
	);

	// erReg never flushes, the branch itself retires.
	stageReg #(.payloadT(execRetT)) erReg (
		.clk   (clk),
		.rstN  (rstN),
		.hold  (erHold),
		.flush (1'b0),
		.d     (erD),
		.q     (erQ)
	);

	pipeControl control (
		.clk         (clk),
		.rstN        (rstN),
		.instValid   (instValid),
		.instPc      (instPc),
		.erValid     (erQ.valid),
		.creditAvail (creditAvail),
		.branchTaken (branchTaken),
		.target      (target),
		.inReady     (inReady),
		.instKeep    (instKeep),
		.deHold      (deHold),
		.erHold      (erHold),
		.deFlush     (deFlush),
		.retValid    (retValid)
	);

	creditCounter #(.retCredits(retCredits)) credits (
		.clk          (clk),
		.rstN         (rstN),
		.send         (retValid),
		.creditReturn (retCredit),
		.creditAvail  (creditAvail)
	);

endmodule

// File: coreTop_assertions.sv
`timescale 1ns/1ps

module coreTop_assertions #(
	parameter int retCredits = 4
) (
	input logic                                 clk,
	input logic                                 rstN,
	input logic                                 inReady,
	input logic                                 retValid,
	input logic [isaPkg::regIdxW-1:0]           retRd,
	input logic [isaPkg::xlen-1:0]              retValue,
	input logic                                 retCredit,
	input logic [$clog2(retCredits + 1)-1:0]    dutCount
);

	int credits; // count as seen from the port.

	always_ff @(posedge clk) begin
		if (!rstN)
			credits <= retCredits;
		else
			credits <= credits - (retValid ? 1 : 0) + (retCredit ? 1 : 0);
	end

	sendNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
		retValid |-> credits != 0) else $error("retValid high with zero credits");

	countBounded: assert property (@(posedge clk) disable iff (!rstN)
		dutCount <= retCredits) else $error("credit count above its limit");

	zeroRdZeroValue: assert property (@(posedge clk) disable iff (!rstN)
		retValid && retRd == '0 |-> retValue == '0) else $error("rd 0 record with a value");

	quietAfterReset: assert property (@(posedge clk)
		!rstN |=> !inReady && !retValid) else $error("outputs active right after reset");

endmodule

// File: coreTbModel.svh
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

localparam logic [31:0] lcgSeed = 32'h96ed971d;

// next state of the stimulus generator.
function automatic logic [31:0] lcgNext(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// architectural run of the list; a taken target must not be the next entry.
function automatic void refRetire(input logic [31:0] pcs[$], input logic [31:0] insts[$],
		output pipePkg::execRetT recs[$]);
	logic [31:0] x [32];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [31:0] tgt;
	logic [31:0] ins;
	logic [31:0] bImm;
	logic [6:0]  opc;
	logic [4:0]  rd;
	logic        skipping;
	logic        taken;
	logic        wr;
	pipePkg::execRetT rec;
	foreach (x[r])
		x[r] = '0;
	recs = {};
	skipping = 1'b0;
	tgt = '0;
	foreach (insts[i]) begin
		ins = insts[i];
		if (skipping && pcs[i] != tgt)
			continue; // wrong path.
		skipping = 1'b0;
		opc = ins[6:0];
		a = x[ins[19:15]];
		b = (opc == isaPkg::opImm) ? {{20{ins[31]}}, ins[31:20]} : x[ins[24:20]];
		bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		taken = 1'b0;
		wr = 1'b1;
		res = '0;
		if (opc == isaPkg::opOp || opc == isaPkg::opImm) begin
			case (ins[14:12])
				3'd0: res = (opc == isaPkg::opOp && ins[30]) ? a - b : a + b;
				3'd1: res = a << b[4:0];
				3'd2: res = {31'b0, $signed(a) < $signed(b)};
				3'd3: res = {31'b0, a < b};
				3'd4: res = a ^ b;
				3'd5: begin
					if (ins[30])
						res = $signed(a) >>> b[4:0];
					else
						res = a >> b[4:0];
				end
				3'd6: res = a | b;
				default: res = a & b;
			endcase
		end else if (opc == isaPkg::opLui) begin
			res = {ins[31:12], 12'b0};
		end else if (opc == isaPkg::opAuipc) begin
			res = pcs[i] + {ins[31:12], 12'b0};
		end else if (opc == isaPkg::opJal) begin
			res = pcs[i] + 32'd4;
			taken = 1'b1;
			tgt = pcs[i] + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		end else if (opc == isaPkg::opBranch) begin
			wr = 1'b0;
			b = x[ins[24:20]];
			case (ins[14:12])
				3'd0: taken = a == b;
				3'd1: taken = a != b;
				3'd4: taken = $signed(a) < $signed(b);
				3'd5: taken = $signed(a) >= $signed(b);
				3'd6: taken = a < b;
				3'd7: taken = a >= b;
				default: taken = 1'b0;
			endcase
			tgt = pcs[i] + bImm;
		end else begin
			wr = 1'b0;
		end
		rd = wr ? ins[11:7] : 5'd0;
		if (rd != 5'd0)
			x[rd] = res;
		rec.valid = 1'b1;
		rec.pc = pcs[i];
		rec.rd = rd;
		rec.value = (rd == 5'd0) ? 32'd0 : res;
		rec.regWrite = wr;
		recs.push_back(rec);
		skipping = taken;
	end
endfunction

`endif

// File: coreTb.sv
`timescale 1ns/1ps

module coreTb;
	import isaPkg::*;
	import pipePkg::*;

	`include "coreTbModel.svh"

	localparam int retCredits = 4;
	localparam int holdCycles = 40; // credits held back in the stall test.

	logic               clk = 1'b0;
	logic               rstN;
	logic               instValid;
	logic [xlen-1:0]    instPc;
	logic [instW-1:0]   inst;
	logic               inReady;
	logic               retValid;
	logic [xlen-1:0]    retPc;
	logic [regIdxW-1:0] retRd;
	logic [xlen-1:0]    retValue;
	logic               retCredit;

	logic [31:0] pcs[$];
	logic [31:0] insts[$];
	execRetT     expQ[$];
	logic [31:0] rng = lcgSeed;
	logic [31:0] curPc;
	int          progLen = 0;
	int          expTotal = 0;
	int          edgeNo = 0;
	int          acceptEdge = 0;
	int          recvCnt = 0;
	int          retCnt = 0;
	logic        stallPhase = 1'b0;
	logic        withholding = 1'b0;
	logic        sawStall = 1'b0;

	coreTop #(.retCredits(retCredits)) coreTop_inst (
		.clk       (clk),
		.rstN      (rstN),
		.instValid (instValid),
		.instPc    (instPc),
		.inst      (inst),
		.inReady   (inReady),
		.retValid  (retValid),
		.retPc     (retPc),
		.retRd     (retRd),
		.retValue  (retValue),
		.retCredit (retCredit)
	);

	bind coreTop coreTop_assertions #(.retCredits(retCredits)) coreTop_assertions_inst (
		.clk       (clk),
		.rstN      (rstN),
		.inReady   (inReady),
		.retValid  (retValid),
		.retRd     (retRd),
		.retValue  (retValue),
		.retCredit (retCredit),
		.dutCount  (credits.count)
	);

	always #50 clk = ~clk;

	always @(negedge clk) edgeNo <= edgeNo + 1; // stable at every rising edge.

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] rand32();
		rng = lcgNext(rng);
		return rng;
	endfunction

	function automatic logic [31:0] pick(input logic [31:0] n);
		return (rand32() >> 16) % n; // drop the weak low lcg bits.
	endfunction

	function automatic logic [31:0] opInst(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic logic [31:0] immInst(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, opImm};
	endfunction

	function automatic logic [31:0] upperInst(input logic [6:0] opc, input logic [19:0] imm,
			input logic [4:0] rd);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jalInst(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	function automatic logic [31:0] branchInst(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	// OP or OP-IMM with any funct3 including sub and sra.
	function automatic logic [31:0] randomAlu(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		f3 = 3'(pick(8));
		alt = pick(2) == 32'd1;
		imm = 12'(rand32() >> 20);
		if (pick(2) == 32'd0)
			return opInst((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
		if (f3 == 3'd1 || f3 == 3'd5)
			imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]}; // shamt form.
		return immInst(imm, rs1, f3, rd);
	endfunction

	task automatic pushInst(input logic [31:0] w);
		pcs.push_back(curPc);
		insts.push_back(w);
		curPc = curPc + 32'd4;
	endtask

	// each test owns one 4 KiB pc window.
	task automatic buildProgram();
		logic [2:0] bF3 [6];
		logic [4:0] rd;
		logic [4:0] prev1;
		logic [4:0] prev2;
		logic [4:0] same;
		int         r;
		int         g;
		int         j;
		int         k;
		bF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		curPc = 32'h1000;
		pushInst(immInst(12'h5a3, 5'd0, 3'd0, 5'd1));
		curPc = 32'h2000;
		for (r = 2; r < 32; r++) begin // every register gets a value first.
			if (r % 2 == 1)
				pushInst(upperInst(opLui, 20'(rand32() >> 12), 5'(r)));
			else
				pushInst(immInst(12'(rand32() >> 20), 5'd0, 3'd0, 5'(r)));
		end
		for (j = 0; j < 40; j++)
			pushInst(randomAlu(5'(pick(32)), 5'(pick(32)), 5'(pick(32))));
		curPc = 32'h3000;
		prev1 = 5'd1;
		prev2 = 5'd2;
		for (j = 0; j < 16; j++) begin
			rd = 5'(10 + j % 10);
			if (pick(2) == 32'd0)
				pushInst(randomAlu(rd, prev1, prev2));
			else
				pushInst(randomAlu(rd, prev2, prev1));
			prev2 = prev1;
			prev1 = rd;
		end
		curPc = 32'h4000;
		for (g = 0; g < 12; g++) begin
			pushInst(randomAlu(5'(1 + pick(31)), 5'(pick(32)), 5'(pick(32))));
			if (pick(3) == 32'd0)
				pushInst(upperInst(opAuipc, 20'(rand32() >> 12), 5'(1 + pick(31))));
			k = 1 + int'(pick(3));
			case (pick(4))
				32'd0: pushInst(jalInst(21'(4 * (k + 1)), 5'(1 + pick(31))));
				32'd1: begin
					same = 5'(1 + pick(31));
					pushInst(branchInst(13'(4 * (k + 1)), same, same, 3'd0));
				end
				default: begin
					pushInst(branchInst(13'(4 * (k + 1)), 5'(pick(32)), 5'(pick(32)),
						bF3[pick(6)]));
				end
			endcase
			for (j = 0; j < k; j++) // skipped when taken.
				pushInst(immInst(12'(rand32() >> 20), 5'd0, 3'd0, 5'(1 + pick(31))));
		end
		pushInst(immInst(12'h001, 5'd0, 3'd0, 5'd1)); // landing spot of the last jump.
		curPc = 32'h5000;
		for (j = 0; j < 14; j++) begin
			if (j == 6)
				pushInst(32'h00000f8f); // no supported opcode.
			else
				pushInst(randomAlu(5'(pick(32)), 5'(pick(32)), 5'(pick(32))));
		end
	endtask

	function automatic string testName(input logic [31:0] pc);
		case (pc[15:12])
			4'd1:    return "single addi";
			4'd2:    return "random alu";
			4'd3:    return "forwarding";
			4'd4:    return "branch and jal";
			4'd5:    return "credit stall";
			default: return "unknown";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input logic [xlen-1:0] expected,
			input logic [xlen-1:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic checkReg(input string name, input logic [regIdxW-1:0] expected,
			input logic [regIdxW-1:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
	endtask

	always @(posedge clk) begin : compareRetire
		execRetT want;
		if (rstN === 1'b1 && retValid === 1'b1) begin
			if (expQ.size() == 0) begin
				stopWithFailure("a retire record arrived after all expected records");
			end else begin
				want = expQ.pop_front();
				checkWord({testName(want.pc), " pc"}, want.pc, retPc);
				checkReg({testName(want.pc), " rd"}, want.rd, retRd);
				checkWord({testName(want.pc), " value"}, want.value, retValue);
				if (recvCnt == 0)
					checkWord("single addi latency", xlen'(acceptEdge + 2), xlen'(edgeNo));
				recvCnt = recvCnt + 1;
				if (recvCnt - retCnt > retCredits)
					stopWithFailure("more records outstanding than the consumer has slots");
				if (want.pc[15:12] == 4'd5)
					stallPhase = 1'b1;
			end
		end
		if (withholding && rstN === 1'b1 && inReady === 1'b0)
			sawStall = 1'b1;
	end

	// frees one slot per received record after a random delay.
	initial begin : consumer
		wait (rstN === 1'b1);
		forever begin
			@(negedge clk);
			if (stallPhase && !withholding && !sawStall) begin
				withholding = 1'b1;
				retCredit = 1'b0;
				repeat (holdCycles) @(negedge clk);
				withholding = 1'b0;
			end
			if (recvCnt > retCnt && pick(4) != 32'd0) begin
				retCredit = 1'b1;
				retCnt = retCnt + 1;
			end else begin
				retCredit = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (progLen != 0);
		repeat (progLen * 20 + holdCycles) @(posedge clk);
		stopWithFailure("timeout: the core stopped retiring before the program was done");
	end

	initial begin : mainSeq
		int idx;
		rstN = 1'b0;
		instValid = 1'b0;
		instPc = '0;
		inst = '0;
		retCredit = 1'b0;
		buildProgram();
		refRetire(pcs, insts, expQ);
		expTotal = expQ.size();
		progLen = insts.size();
		repeat (4) begin
			@(negedge clk);
			checkFlag("reset inReady", 1'b0, inReady);
			checkFlag("reset retValid", 1'b0, retValid);
		end
		rstN = 1'b1;
		idx = 0;
		while (idx < progLen) begin
			instValid = 1'b1;
			instPc = pcs[idx];
			inst = insts[idx];
			@(posedge clk);
			if (inReady) begin
				if (idx == 0)
					acceptEdge = edgeNo;
				idx++;
			end
			@(negedge clk);
		end
		instValid = 1'b0;
		wait (recvCnt == expTotal);
		repeat (10) @(posedge clk); // catch trailing extra records.
		checkFlag("credit stall inReady low", 1'b1, sawStall);
		if (recvCnt != expTotal || expQ.size() != 0) begin
			stopWithFailure("expected retire records are missing at the end of the run");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// File: sim.f
+incdir+.
isaPkg.sv
pipePkg.sv
regFile.sv
decodeUnit.sv
stageReg.sv
executeUnit.sv
pipeControl.sv
creditCounter.sv
coreTop.sv
coreTop_assertions.sv
coreTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module coreTb -o coreTbSim

./obj_dir/coreTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
	echo "simulation did not pass"
	exit 1
fi
echo "simulation passed"
